// File: source/sigdecode_z_pkg.sv
// Shared widths, lane counts and memory request types, imported by every z decoder block
`default_nettype none

package sigdecode_z_pkg;

    // ======================================================================
    // Arithmetic constants
    // ======================================================================

    // ML-DSA prime modulus q = 2^23 - 2^13 + 1
    localparam int unsigned mldsa_q = 8380417;

    // Widths of the values that move through the decoder
    localparam int unsigned coeff_width    = 24;
    localparam int unsigned enc_width      = 20;
    localparam int unsigned mem_addr_width = 15;
    localparam int unsigned batch_width    = 16;

    // Each memory port word holds four coefficients, and a batch spans both ports
    localparam int unsigned lanes_per_port = 4;
    localparam int unsigned num_lanes      = 8;

    // ======================================================================
    // Types
    // ======================================================================

    // One coefficient modulo q, as stored in the polynomial memory
    typedef logic [coeff_width-1:0]    coeff_t;

    // One encoded z value; wide enough for gamma1 = 2^19, upper bits zero for 2^17
    typedef logic [enc_width-1:0]      enc_t;

    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // Batch number within one run
    typedef logic [batch_width-1:0]    batch_t;

    // Command field of a memory request
    typedef enum logic [1:0] {
        rw_idle  = 2'b00,
        rw_read  = 2'b01,
        rw_write = 2'b10
    } rw_cmd_t;

    // A request is only acted on when rd_wr_en is not rw_idle
    typedef struct packed {
        rw_cmd_t   rd_wr_en;
        mem_addr_t addr;
    } mem_req_t;

endpackage

`default_nettype wire

// File: source/z_batch_if.sv
// Batch bus from the signature memory reader through the decode lanes to the polynomial writer
`timescale 1ns/100ps
`default_nettype none

interface z_batch_if;
    import sigdecode_z_pkg::*;

    // High for one cycle per returned batch
    logic   valid;

    // Return number of the batch, used by the writer to form the address
    batch_t batch;

    // Destination base address locked at start
    mem_addr_t dest;

    // Encoded values, lanes 0 to 3 from the first row and 4 to 7 from the second
    enc_t   enc [num_lanes];

    // Decoded coefficients, one lane per decode unit, one cycle behind enc
    coeff_t dec [num_lanes];

    // The reader fills the batch
    modport reader (
        output valid,
        output batch,
        output dest,
        output enc
    );

    // Each decode unit touches only its own lane of enc and dec
    modport unit (
        input  enc,
        output dec
    );

    // The writer drains the decoded lanes
    modport writer (
        input  valid,
        input  batch,
        input  dest,
        input  dec
    );

endinterface

`default_nettype wire

// File: source/sigmem_reader.sv
// Start control and read sequencer; fetches encoded batches and numbers them as they return
`timescale 1ns/100ps
`default_nettype none

module sigmem_reader
    #(
        parameter int unsigned num_batches = 8
    )
    (
        input  logic                           clk,
        input  logic                           reset_n,
        input  logic                           zeroize,
        input  logic                           enable,
        input  sigdecode_z_pkg::mem_addr_t     dest_base_addr,
        output sigdecode_z_pkg::mem_req_t      sigmem_rd_req,
        input  sigdecode_z_pkg::enc_t [1:0][sigdecode_z_pkg::lanes_per_port-1:0] sigmem_rd_data,
        input  logic                           sigmem_rd_data_valid,
        z_batch_if.reader                      batch_out
    );
    import sigdecode_z_pkg::*;

    localparam batch_t last_batch = batch_t'(num_batches - 1);

    typedef enum logic {
        st_idle,
        st_read
    } rd_state_t;

    rd_state_t state;
    rd_state_t next_state;

    // Address of the next read while in st_read
    batch_t    rd_cnt;

    // Number given to the next batch that comes back from memory
    batch_t    ret_cnt;

    mem_addr_t dest_lock;

    // Enable only counts while nothing is being read
    logic      start;

    assign start = (state == st_idle) && enable;

    // ======================================================================
    // Read sequencing
    // ======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
        end
        else if (zeroize) begin
            state <= st_idle;
        end
        else begin
            state <= next_state;
        end
    end

    // Address 0 is issued straight from idle, so st_read covers addresses 1 and up
    always_comb begin
        next_state = state;
        unique case (state)
            st_idle: begin
                if (start && (last_batch != '0)) begin
                    next_state = st_read;
                end
            end
            st_read: begin
                if (rd_cnt == last_batch) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Registered read request, one address per cycle, and the destination lock
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sigmem_rd_req <= '{rd_wr_en: rw_idle, addr: '0};
            rd_cnt        <= '0;
            dest_lock     <= '0;
        end
        else if (zeroize) begin
            sigmem_rd_req <= '{rd_wr_en: rw_idle, addr: '0};
            rd_cnt        <= '0;
            dest_lock     <= '0;
        end
        else if (start) begin
            sigmem_rd_req <= '{rd_wr_en: rw_read, addr: '0};
            rd_cnt        <= batch_t'(1);
            dest_lock     <= dest_base_addr;
        end
        else if (state == st_read) begin
            sigmem_rd_req <= '{rd_wr_en: rw_read, addr: mem_addr_t'(rd_cnt)};
            rd_cnt        <= rd_cnt + 1'b1;
        end
        else begin
            sigmem_rd_req <= '{rd_wr_en: rw_idle, addr: '0};
        end
    end

    // ======================================================================
    // Return capture
    // ======================================================================

    // Data comes back in request order, so a wrapping count names each batch
    // no matter how long the memory took
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            batch_out.valid <= 1'b0;
            batch_out.batch <= '0;
            batch_out.dest  <= '0;
            ret_cnt         <= '0;
        end
        else if (zeroize) begin
            batch_out.valid <= 1'b0;
            batch_out.batch <= '0;
            batch_out.dest  <= '0;
            ret_cnt         <= '0;
        end
        else begin
            batch_out.valid <= sigmem_rd_data_valid;
            if (sigmem_rd_data_valid) begin
                batch_out.batch <= ret_cnt;
                batch_out.dest  <= dest_lock;
                ret_cnt         <= (ret_cnt == last_batch) ? '0 : ret_cnt + 1'b1;
            end
        end
    end

    // Encoded payload; zeroize still wipes it since it is signature material
    always_ff @(posedge clk) begin
        if (zeroize) begin
            batch_out.enc <= '{default: '0};
        end
        else if (sigmem_rd_data_valid) begin
            for (int r = 0; r < 2; r++) begin
                for (int l = 0; l < lanes_per_port; l++) begin
                    batch_out.enc[r*lanes_per_port + l] <= sigmem_rd_data[r][l];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sigdecode_z_unit.sv
// One decode lane; maps an encoded z value to gamma1 minus the value, reduced modulo q
`timescale 1ns/100ps
`default_nettype none

module sigdecode_z_unit
    #(
        parameter int unsigned lane       = 0,
        parameter int unsigned gamma1_log = 19
    )
    (
        input  logic      clk,
        input  logic      reset_n,
        input  logic      zeroize,
        z_batch_if.unit   lane_if
    );
    import sigdecode_z_pkg::*;

    localparam coeff_t gamma1        = coeff_t'(1 << gamma1_log);
    localparam coeff_t q_plus_gamma1 = coeff_t'(mldsa_q + (1 << gamma1_log));

    coeff_t enc_ext;
    coeff_t dec_next;

    assign enc_ext = coeff_t'(lane_if.enc[lane]);

    // Values up to gamma1 give a result in [0, gamma1]; larger ones are negative
    // and wrap around by adding q
    always_comb begin
        if (enc_ext <= gamma1) begin
            dec_next = gamma1 - enc_ext;
        end
        else begin
            dec_next = q_plus_gamma1 - enc_ext;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane_if.dec[lane] <= '0;
        end
        else if (zeroize) begin
            lane_if.dec[lane] <= '0;
        end
        else begin
            lane_if.dec[lane] <= dec_next;
        end
    end

endmodule

`default_nettype wire

// File: source/polymem_writer.sv
// Writes each decoded batch to the polynomial memory on two ports and flags the end of a run
`timescale 1ns/100ps
`default_nettype none

module polymem_writer
    #(
        parameter int unsigned num_batches = 8
    )
    (
        input  logic                      clk,
        input  logic                      reset_n,
        input  logic                      zeroize,
        z_batch_if.writer                 batch_in,
        output sigdecode_z_pkg::mem_req_t mem_a_wr_req,
        output sigdecode_z_pkg::mem_req_t mem_b_wr_req,
        output sigdecode_z_pkg::coeff_t [sigdecode_z_pkg::lanes_per_port-1:0] mem_a_wr_data,
        output sigdecode_z_pkg::coeff_t [sigdecode_z_pkg::lanes_per_port-1:0] mem_b_wr_data,
        output logic                      done
    );
    import sigdecode_z_pkg::*;

    localparam batch_t last_batch = batch_t'(num_batches - 1);

    // Batch control delayed by one cycle, level with the decode unit outputs
    logic      valid_d;
    batch_t    batch_d;
    mem_addr_t dest_d;

    // Port a address; port b takes the next one
    mem_addr_t wr_addr;

    // The final batch was written in the previous cycle
    logic      last_wr;

    // Two memory words per batch
    assign wr_addr = dest_d + mem_addr_t'({batch_d, 1'b0});

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_d <= 1'b0;
            batch_d <= '0;
            dest_d  <= '0;
        end
        else if (zeroize) begin
            valid_d <= 1'b0;
            batch_d <= '0;
            dest_d  <= '0;
        end
        else begin
            valid_d <= batch_in.valid;
            batch_d <= batch_in.batch;
            dest_d  <= batch_in.dest;
        end
    end

    // ======================================================================
    // Write requests and completion
    // ======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_a_wr_req <= '{rd_wr_en: rw_idle, addr: '0};
            mem_b_wr_req <= '{rd_wr_en: rw_idle, addr: '0};
            last_wr      <= 1'b0;
            done         <= 1'b0;
        end
        else if (zeroize) begin
            mem_a_wr_req <= '{rd_wr_en: rw_idle, addr: '0};
            mem_b_wr_req <= '{rd_wr_en: rw_idle, addr: '0};
            last_wr      <= 1'b0;
            done         <= 1'b0;
        end
        else begin
            if (valid_d) begin
                mem_a_wr_req <= '{rd_wr_en: rw_write, addr: wr_addr};
                mem_b_wr_req <= '{rd_wr_en: rw_write, addr: wr_addr + mem_addr_t'(1)};
            end
            else begin
                mem_a_wr_req <= '{rd_wr_en: rw_idle, addr: '0};
                mem_b_wr_req <= '{rd_wr_en: rw_idle, addr: '0};
            end
            // Done trails the last write by one cycle
            last_wr <= valid_d && (batch_d == last_batch);
            done    <= last_wr;
        end
    end

    // Write data rides with the request; lanes 0 to 3 on port a, 4 to 7 on port b
    always_ff @(posedge clk) begin
        if (zeroize) begin
            mem_a_wr_data <= '0;
            mem_b_wr_data <= '0;
        end
        else if (valid_d) begin
            for (int l = 0; l < lanes_per_port; l++) begin
                mem_a_wr_data[l] <= batch_in.dec[l];
                mem_b_wr_data[l] <= batch_in.dec[lanes_per_port + l];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sigdecode_z_top.sv
// Top level of the z vector signature decoder; connect to the signature and polynomial memories
`timescale 1ns/100ps
`default_nettype none

module sigdecode_z_top
    #(
        parameter int unsigned num_batches = 8,
        // Exponent of gamma1, 17 or 19
        parameter int unsigned gamma1_log  = 19
    )
    (
        input  logic                      clk,
        input  logic                      reset_n,
        input  logic                      zeroize,

        // Control
        input  logic                      sigdecode_z_enable,
        output logic                      sigdecode_z_done,
        input  sigdecode_z_pkg::mem_addr_t dest_base_addr,

        // Signature memory read side
        output sigdecode_z_pkg::mem_req_t sigmem_rd_req,
        input  sigdecode_z_pkg::enc_t [1:0][sigdecode_z_pkg::lanes_per_port-1:0] sigmem_rd_data,
        input  logic                      sigmem_rd_data_valid,

        // Polynomial memory write ports
        output sigdecode_z_pkg::mem_req_t mem_a_wr_req,
        output sigdecode_z_pkg::coeff_t [sigdecode_z_pkg::lanes_per_port-1:0] mem_a_wr_data,
        output sigdecode_z_pkg::mem_req_t mem_b_wr_req,
        output sigdecode_z_pkg::coeff_t [sigdecode_z_pkg::lanes_per_port-1:0] mem_b_wr_data
    );
    import sigdecode_z_pkg::*;

    z_batch_if batch_bus ();

    sigmem_reader #(
        .num_batches          (num_batches)
    ) u_reader (
        .clk                  (clk),
        .reset_n              (reset_n),
        .zeroize              (zeroize),
        .enable               (sigdecode_z_enable),
        .dest_base_addr       (dest_base_addr),
        .sigmem_rd_req        (sigmem_rd_req),
        .sigmem_rd_data       (sigmem_rd_data),
        .sigmem_rd_data_valid (sigmem_rd_data_valid),
        .batch_out            (batch_bus.reader)
    );

    // One decode unit per lane of the batch
    generate
        for (genvar i = 0; i < num_lanes; i++) begin : dec_unit
            sigdecode_z_unit #(
                .lane       (i),
                .gamma1_log (gamma1_log)
            ) u_unit (
                .clk        (clk),
                .reset_n    (reset_n),
                .zeroize    (zeroize),
                .lane_if    (batch_bus.unit)
            );
        end : dec_unit
    endgenerate

    polymem_writer #(
        .num_batches   (num_batches)
    ) u_writer (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .batch_in      (batch_bus.writer),
        .mem_a_wr_req  (mem_a_wr_req),
        .mem_b_wr_req  (mem_b_wr_req),
        .mem_a_wr_data (mem_a_wr_data),
        .mem_b_wr_data (mem_b_wr_data),
        .done          (sigdecode_z_done)
    );

endmodule

`default_nettype wire

// File: tests/sigdecode_z_tb.sv
// Self-checking testbench for the z decoder; runs every case of the cases file on one DUT per gamma1
`timescale 1ns/100ps
`default_nettype none

module sigdecode_z_tb;
    import sigdecode_z_pkg::*;

    localparam int unsigned num_batches  = 8;
    localparam int unsigned reset_cycles = 10;
    // A run in the cases file is gamma1 exponent, mode, base, second base, then four value pairs
    localparam int unsigned case_words   = 12;
    localparam int unsigned edge_count   = 4;
    localparam int unsigned max_runs     = 16;
    localparam int unsigned batch_values = num_batches * num_lanes;

    logic      clk;
    logic      reset_n;
    logic      zeroize;
    mem_addr_t dest_base;
    enc_t [1:0][lanes_per_port-1:0] rd_data;

    // Index 0 is the DUT with gamma1 = 2^17, index 1 the one with 2^19
    logic      enable [2];
    logic      rd_valid [2];
    logic      done [2];
    mem_req_t  rd_req [2];
    mem_req_t  a_req [2];
    mem_req_t  b_req [2];
    coeff_t [lanes_per_port-1:0] a_data [2];
    coeff_t [lanes_per_port-1:0] b_data [2];

    logic [31:0] cases_mem [0:max_runs*case_words];

    // State of the run in progress
    int unsigned sel;
    mem_addr_t   run_base;
    enc_t        run_enc [batch_values];
    coeff_t      run_exp [batch_values];
    int unsigned rd_seen;
    int unsigned wr_seen;
    int unsigned done_seen;
    int unsigned tick_n;
    int unsigned cycle_cnt;
    int unsigned cycle_limit;

    // Outstanding reads of the memory model, oldest first
    int unsigned pend_addr [$];
    int unsigned pend_due [$];

    generate
        for (genvar i = 0; i < 2; i++) begin : g_dut
            sigdecode_z_top #(
                .num_batches          (num_batches),
                .gamma1_log           ((i == 0) ? 17 : 19)
            ) u_dut (
                .clk                  (clk),
                .reset_n              (reset_n),
                .zeroize              (zeroize),
                .sigdecode_z_enable   (enable[i]),
                .sigdecode_z_done     (done[i]),
                .dest_base_addr       (dest_base),
                .sigmem_rd_req        (rd_req[i]),
                .sigmem_rd_data       (rd_data),
                .sigmem_rd_data_valid (rd_valid[i]),
                .mem_a_wr_req         (a_req[i]),
                .mem_a_wr_data        (a_data[i]),
                .mem_b_wr_req         (b_req[i]),
                .mem_b_wr_data        (b_data[i])
            );
        end : g_dut
    endgenerate

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // The limit is only armed once the cases file has been sized
    always @(posedge clk) begin
        cycle_cnt++;
        if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit)) begin
            stop_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // ======================================================================
    // Reference model and checks
    // ======================================================================

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Values up to gamma1 map to gamma1 minus the value, larger ones wrap by adding q
    function automatic coeff_t decode_rule(input enc_t value, input int unsigned gamma1);
        if (value <= gamma1) begin
            return coeff_t'(gamma1 - value);
        end
        else begin
            return coeff_t'(mldsa_q + gamma1 - value);
        end
    endfunction

    task automatic check_idle();
        for (int i = 0; i < 2; i++) begin
            check_value("sigmem_rd_req", rd_req[i], 0);
            check_value("mem_a_wr_req", a_req[i], 0);
            check_value("mem_b_wr_req", b_req[i], 0);
            check_value("sigdecode_z_done", done[i], 0);
        end
        check_value("batch_bus.valid", g_dut[0].u_dut.batch_bus.valid, 0);
        check_value("batch_bus.valid", g_dut[1].u_dut.batch_bus.valid, 0);
    endtask

    // Write ports and done of the selected DUT; writes come back in batch order
    task automatic check_writes();
        int unsigned b;
        b = wr_seen / 2;
        if (a_req[sel].rd_wr_en == rw_write) begin
            if (done_seen != 0) begin
                stop_run("a write request appeared after done");
            end
            if (b >= num_batches) begin
                stop_run("more batches were written than were read");
            end
            check_value("mem_a_wr_req.addr", a_req[sel].addr, mem_addr_t'(run_base + 2*b));
            check_value("mem_b_wr_req.rd_wr_en", b_req[sel].rd_wr_en, rw_write);
            check_value("mem_b_wr_req.addr", b_req[sel].addr, mem_addr_t'(run_base + 2*b + 1));
            for (int l = 0; l < lanes_per_port; l++) begin
                check_value($sformatf("mem_a_wr_data[%0d]", l), a_data[sel][l],
                            run_exp[b*num_lanes + l]);
                check_value($sformatf("mem_b_wr_data[%0d]", l), b_data[sel][l],
                            run_exp[b*num_lanes + lanes_per_port + l]);
            end
            wr_seen += 2;
        end
        else begin
            check_value("mem_b_wr_req.rd_wr_en", b_req[sel].rd_wr_en, rw_idle);
        end
        if (done[sel]) begin
            check_value("done pulses per run", done_seen, 0);
            check_value("writes before done", wr_seen, 2*num_batches);
            done_seen++;
        end
    endtask

    // ======================================================================
    // Memory model and stimulus
    // ======================================================================

    // One falling edge: return due data, check outputs, then accept a new read
    task automatic tick();
        int unsigned addr;
        int unsigned due;
        @(negedge clk);
        tick_n++;
        rd_valid[0] = 1'b0;
        rd_valid[1] = 1'b0;
        if ((pend_due.size() > 0) && (pend_due[0] == tick_n)) begin
            addr = pend_addr.pop_front();
            due  = pend_due.pop_front();
            for (int r = 0; r < 2; r++) begin
                for (int l = 0; l < lanes_per_port; l++) begin
                    rd_data[r][l] = run_enc[addr*num_lanes + r*lanes_per_port + l];
                end
            end
            rd_valid[sel] = 1'b1;
        end
        check_writes();
        if (rd_req[sel].rd_wr_en == rw_read) begin
            check_value("sigmem_rd_req.addr", rd_req[sel].addr, rd_seen);
            rd_seen++;
            // Latency of 1 to 3 cycles, but never overtaking an older read
            due = tick_n + 1 + ($urandom % 3);
            if ((pend_due.size() > 0) && (due <= pend_due[$])) begin
                due = pend_due[$] + 1;
            end
            pend_addr.push_back(rd_req[sel].addr);
            pend_due.push_back(due);
        end
        else begin
            check_value("sigmem_rd_req", rd_req[sel], 0);
        end
    endtask

    task automatic flush_reads();
        pend_addr.delete();
        pend_due.delete();
        rd_valid[0] = 1'b0;
        rd_valid[1] = 1'b0;
    endtask

    task automatic start_run(input mem_addr_t base);
        rd_seen   = 0;
        wr_seen   = 0;
        done_seen = 0;
        tick();
        enable[sel] = 1'b1;
        dest_base   = base;
        tick();
        enable[sel] = 1'b0;
        dest_base   = '0;
        // The first read leaves in the cycle right after enable
        check_value("reads one cycle after enable", rd_seen, 1);
    endtask

    // Mode 0 is a plain run, 1 adds a zeroize mid-run, 2 adds an enable while busy
    task automatic run_case(input int unsigned idx);
        int unsigned w;
        int unsigned mode;
        int unsigned gamma1;
        w        = 1 + idx*case_words;
        mode     = cases_mem[w+1];
        run_base = mem_addr_t'(cases_mem[w+2]);
        if (cases_mem[w] == 17) begin
            sel = 0;
        end
        else if (cases_mem[w] == 19) begin
            sel = 1;
        end
        else begin
            stop_run("the cases file holds a gamma1 exponent other than 17 or 19");
        end
        gamma1 = 1 << cases_mem[w];
        // Edge values from the file first, legal random values for the rest
        for (int k = 0; k < batch_values; k++) begin
            if (k < edge_count) begin
                run_enc[k] = enc_t'(cases_mem[w + 4 + 2*k]);
            end
            else begin
                run_enc[k] = enc_t'($urandom % (2*gamma1));
            end
            // Every expected coefficient comes from the decode rule
            run_exp[k] = decode_rule(run_enc[k], gamma1);
        end
        if (mode == 1) begin
            start_run(run_base);
            repeat (4) tick();
            zeroize = 1'b1;
            flush_reads();
            tick();
            zeroize = 1'b0;
            check_idle();
        end
        start_run(run_base);
        if (mode == 2) begin
            repeat (3) tick();
            enable[sel] = 1'b1;
            dest_base   = mem_addr_t'(cases_mem[w+3]);
            tick();
            enable[sel] = 1'b0;
            dest_base   = '0;
        end
        while (done_seen == 0) begin
            tick();
        end
        // A few quiet cycles catch late writes or a second done
        repeat (4) tick();
        check_value("read requests per run", rd_seen, num_batches);
        check_value("write requests per run", wr_seen, 2*num_batches);
    endtask

    initial begin
        int unsigned runs;
        int unsigned total;
        void'($urandom(26));
        reset_n     = 1'b0;
        zeroize     = 1'b0;
        dest_base   = '0;
        rd_data     = '0;
        enable[0]   = 1'b0;
        enable[1]   = 1'b0;
        rd_valid[0] = 1'b0;
        rd_valid[1] = 1'b0;
        sel         = 0;
        tick_n      = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        $readmemh("tests/sigdecode_z_cases.txt", cases_mem);
        runs = cases_mem[0];
        if ((runs == 0) || (runs > max_runs)) begin
            stop_run("the cases file has no usable run count");
        end
        // A zeroize case is run twice, the aborted part and the full rerun
        total = runs;
        for (int r = 0; r < runs; r++) begin
            if (cases_mem[1 + r*case_words + 1] == 1) begin
                total++;
            end
        end
        cycle_limit = reset_cycles + total * (num_batches + 20);
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
        tick();
        check_idle();
        for (int r = 0; r < runs; r++) begin
            run_case(r);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/sigdecode_z_cases.txt
// Word 0 is the run count; each run is gamma1 exponent, mode, base, second base,
// then four pairs of encoded value and expected coefficient (mode 1 zeroize, 2 busy enable)
5
// gamma1 = 2^17 at base 0 with 0, gamma1, gamma1 + 1 and 2*gamma1 - 1
11 0 0000 0000
00000 20000 20000 00000 20001 7FE000 3FFFF 7BE002
// gamma1 = 2^19 at base 0x100 with the same edges
13 0 0100 0000
00000 80000 80000 00000 80001 7FE000 FFFFF 75E002
// Zeroize mid-run, then a full rerun
11 1 4000 0000
00001 1FFFF 3FFFF 7BE002 20001 7FE000 20000 00000
// Enable again while busy with another base, which must be ignored
13 2 0230 1234
FFFFF 75E002 00001 7FFFF 80000 00000 80001 7FE000
// Base near the top of the address space
13 0 7FF0 0000
7FFFF 00001 80002 7FDFFF 00000 80000 FFFFF 75E002

// File: src.f
source/sigdecode_z_pkg.sv
source/z_batch_if.sv
source/sigmem_reader.sv
source/sigdecode_z_unit.sv
source/polymem_writer.sv
source/sigdecode_z_top.sv
tests/sigdecode_z_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -rf obj_dir build.log sim.log
verilator --binary -Wno-fatal --top-module sigdecode_z_tb -f src.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vsigdecode_z_tb > sim.log 2>&1
cat sim.log
grep -qx "Everything OK" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
